/* Makefile */
# Verilator build and run of the CSR file testbench

VERILATOR ?= verilator
TOP       ?= csr_file_tb
FILELIST  ?= csr_file.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_MSG  ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* csr_file.f */
source/csr_pkg.sv
source/csr_access.sv
source/csr_trap_regs.sv
source/csr_counters.sv
source/csr_file.sv
verification/csr_file_assertions.sv
verification/csr_file_tb.sv

/* source/csr_access.sv */
// CSR access control
// read data merge, write data forming for write/set/clear,
// illegal access check and write strobe

`timescale 1ns/1ps

module csr_access (
  // request from the core
  input  logic                csr_access_i,
  input  logic                csr_op_en_i,
  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  csr_pkg::csr_op_e    csr_op_i,
  input  csr_pkg::csr_data_t  csr_wdata_i,

  // current privilege
  input  csr_pkg::priv_lvl_e  priv_lvl_i,

  // read data and hits from the register blocks
  input  csr_pkg::csr_data_t  trap_rdata_i,
  input  logic                trap_hit_i,
  input  csr_pkg::csr_data_t  cnt_rdata_i,
  input  logic                cnt_hit_i,

  // response
  output csr_pkg::csr_data_t  csr_rdata_o,
  output logic                illegal_csr_insn_o,

  // write port to the register blocks
  output logic                csr_we_o,
  output csr_pkg::csr_data_t  csr_wdata_int_o
);

  import csr_pkg::*;

  csr_data_t rdata;
  logic      wreq;
  logic      illegal_addr;
  logic      illegal_priv;
  logic      illegal_write;

  // blocks drive zero when they do not hit, so an OR is enough
  assign rdata       = trap_rdata_i | cnt_rdata_i;
  assign csr_rdata_o = rdata;

  // read is the only op that leaves the register alone
  assign wreq = csr_op_en_i & (csr_op_i != CSR_OP_READ);

  ////////////////////////////////////////////////////////////////////////////
  // legality

  assign illegal_addr = ~(trap_hit_i | cnt_hit_i);

  // bits 9:8 hold the lowest privilege allowed to access
  assign illegal_priv = csr_addr_i[9:8] > 2'(priv_lvl_i);

  // bits 11:10 == 2'b11 marks read-only space
  // mip reflects the interrupt pins and has no storage
  assign illegal_write = wreq & ((csr_addr_i[11:10] == 2'b11) || (csr_addr_i == CSR_MIP));

  assign illegal_csr_insn_o = csr_access_i & (illegal_addr | illegal_priv | illegal_write);

  ////////////////////////////////////////////////////////////////////////////
  // write data

  always_comb begin
    case (csr_op_i)
      CSR_OP_WRITE: csr_wdata_int_o = csr_wdata_i;
      CSR_OP_SET:   csr_wdata_int_o = rdata | csr_wdata_i;
      CSR_OP_CLEAR: csr_wdata_int_o = rdata & ~csr_wdata_i;
      default:      csr_wdata_int_o = csr_wdata_i;
    endcase
  end

  // single-cycle strobe, only for legal enabled writes
  assign csr_we_o = csr_access_i & wreq & ~illegal_csr_insn_o;

endmodule

/* source/csr_counters.sv */
// machine counters
// mcycle and minstret (64 bit each) with mcountinhibit

`timescale 1ns/1ps

module csr_counters (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  csr_pkg::csr_addr_t csr_addr_i,
  input  logic               csr_we_i,
  input  csr_pkg::csr_data_t csr_wdata_i,
  output csr_pkg::csr_data_t rdata_o,
  output logic               hit_o,

  // one pulse per retired instruction
  input  logic               instr_ret_i
);

  import csr_pkg::*;

  logic [CNT_W-1:0] mcycle_q, minstret_q;
  // bit 0 mcycle, bit 2 minstret, bit 1 (time) stuck at 0
  logic [2:0]       mcountinhibit_q;
  logic             mcycle_we, mcycleh_we;
  logic             minstret_we, minstreth_we;
  logic             inhibit_we;

  // a write to either half replaces the increment of that cycle
  function automatic logic [CNT_W-1:0] cnt_next(input logic [CNT_W-1:0] q,
                                                input logic             inc,
                                                input logic             we_lo,
                                                input logic             we_hi,
                                                input csr_data_t        wdata);
    if (we_lo) begin
      return {q[CNT_W-1:32], wdata};
    end else if (we_hi) begin
      return {wdata, q[31:0]};
    end else if (inc) begin
      return q + 1'b1;
    end
    return q;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // read and write decode

  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (csr_addr_i)
      CSR_MCOUNTINHIBIT: rdata_o = {29'b0, mcountinhibit_q};
      CSR_MCYCLE:        rdata_o = mcycle_q[31:0];
      CSR_MCYCLEH:       rdata_o = mcycle_q[CNT_W-1:32];
      CSR_MINSTRET:      rdata_o = minstret_q[31:0];
      CSR_MINSTRETH:     rdata_o = minstret_q[CNT_W-1:32];
      default:           hit_o   = 1'b0;
    endcase
  end

  assign inhibit_we   = csr_we_i & (csr_addr_i == CSR_MCOUNTINHIBIT);
  assign mcycle_we    = csr_we_i & (csr_addr_i == CSR_MCYCLE);
  assign mcycleh_we   = csr_we_i & (csr_addr_i == CSR_MCYCLEH);
  assign minstret_we  = csr_we_i & (csr_addr_i == CSR_MINSTRET);
  assign minstreth_we = csr_we_i & (csr_addr_i == CSR_MINSTRETH);

  ////////////////////////////////////////////////////////////////////////////
  // registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcountinhibit_q <= '0;
      mcycle_q        <= '0;
      minstret_q      <= '0;
    end else begin
      if (inhibit_we) begin
        mcountinhibit_q <= {csr_wdata_i[2], 1'b0, csr_wdata_i[0]};
      end
      mcycle_q   <= cnt_next(mcycle_q, ~mcountinhibit_q[0], mcycle_we, mcycleh_we,
                             csr_wdata_i);
      minstret_q <= cnt_next(minstret_q, instr_ret_i & ~mcountinhibit_q[2], minstret_we,
                             minstreth_we, csr_wdata_i);
    end
  end

endmodule

/* source/csr_file.sv */
// machine-mode CSR file top level
// connects access control, trap registers and counters

`timescale 1ns/1ps

module csr_file (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // CSR access, answered in the same cycle
  input  logic                        csr_access_i,
  input  csr_pkg::csr_addr_t          csr_addr_i,
  input  csr_pkg::csr_op_e            csr_op_i,
  input  logic                        csr_op_en_i,
  input  csr_pkg::csr_data_t          csr_wdata_i,
  output csr_pkg::csr_data_t          csr_rdata_o,
  output logic                        illegal_csr_insn_o,

  // interrupts
  input  logic                        irq_software_i,
  input  logic                        irq_timer_i,
  input  logic                        irq_external_i,
  output logic                        irq_pending_o,
  output logic                        csr_mstatus_mie_o,

  // traps
  input  logic                        csr_save_cause_i,
  input  logic                        csr_restore_mret_i,
  input  csr_pkg::csr_data_t          csr_trap_pc_i,
  input  logic [csr_pkg::CAUSE_W-1:0] csr_mcause_i,
  input  csr_pkg::csr_data_t          csr_mtval_i,
  input  logic                        csr_mtvec_init_i,
  input  csr_pkg::csr_data_t          boot_addr_i,
  output csr_pkg::csr_data_t          csr_mtvec_o,
  output csr_pkg::csr_data_t          csr_mepc_o,
  output csr_pkg::priv_lvl_e          priv_mode_o,

  input  logic                        instr_ret_i
);

  import csr_pkg::*;

  csr_data_t trap_rdata;
  logic      trap_hit;
  csr_data_t cnt_rdata;
  logic      cnt_hit;
  logic      csr_we;
  csr_data_t csr_wdata_int;
  priv_lvl_e priv_lvl;

  csr_access u_csr_access (
    .csr_access_i       (csr_access_i),
    .csr_op_en_i        (csr_op_en_i),
    .csr_addr_i         (csr_addr_i),
    .csr_op_i           (csr_op_i),
    .csr_wdata_i        (csr_wdata_i),
    .priv_lvl_i         (priv_lvl),
    .trap_rdata_i       (trap_rdata),
    .trap_hit_i         (trap_hit),
    .cnt_rdata_i        (cnt_rdata),
    .cnt_hit_i          (cnt_hit),
    .csr_rdata_o        (csr_rdata_o),
    .illegal_csr_insn_o (illegal_csr_insn_o),
    .csr_we_o           (csr_we),
    .csr_wdata_int_o    (csr_wdata_int)
  );

  csr_trap_regs u_csr_trap_regs (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .csr_addr_i         (csr_addr_i),
    .csr_we_i           (csr_we),
    .csr_wdata_i        (csr_wdata_int),
    .rdata_o            (trap_rdata),
    .hit_o              (trap_hit),
    .irq_software_i     (irq_software_i),
    .irq_timer_i        (irq_timer_i),
    .irq_external_i     (irq_external_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .csr_mtvec_init_i   (csr_mtvec_init_i),
    .csr_trap_pc_i      (csr_trap_pc_i),
    .csr_mcause_i       (csr_mcause_i),
    .csr_mtval_i        (csr_mtval_i),
    .boot_addr_i        (boot_addr_i),
    .priv_lvl_o         (priv_lvl),
    .csr_mepc_o         (csr_mepc_o),
    .csr_mtvec_o        (csr_mtvec_o),
    .csr_mstatus_mie_o  (csr_mstatus_mie_o),
    .irq_pending_o      (irq_pending_o)
  );

  csr_counters u_csr_counters (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_addr_i  (csr_addr_i),
    .csr_we_i    (csr_we),
    .csr_wdata_i (csr_wdata_int),
    .rdata_o     (cnt_rdata),
    .hit_o       (cnt_hit),
    .instr_ret_i (instr_ret_i)
  );

  assign priv_mode_o = priv_lvl;

endmodule

/* source/csr_pkg.sv */
// shared definitions of the machine-mode CSR file
// CSR numbers, field positions and widths, privilege and operation enums

package csr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // basic types

  typedef logic [31:0] csr_data_t;
  typedef logic [11:0] csr_addr_t;

  // only M and U are implemented
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // CSR numbers

  // machine trap setup and handling
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MIE      = 12'h304;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MTVAL    = 12'h343;
  localparam csr_addr_t CSR_MIP      = 12'h344;

  // counters
  localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
  localparam csr_addr_t CSR_MCYCLE        = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET      = 12'hB02;
  localparam csr_addr_t CSR_MCYCLEH       = 12'hB80;
  localparam csr_addr_t CSR_MINSTRETH     = 12'hB82;

  // machine information, read-only
  localparam csr_addr_t CSR_MHARTID = 12'hF14;
  localparam csr_data_t HART_ID     = 32'h0000_0001;

  ////////////////////////////////////////////////////////////////////////////
  // field positions and widths

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LO   = 11;
  localparam int MSTATUS_MPP_HI   = 12;

  // shared by mie and mip
  localparam int MIX_MSI_BIT = 3;
  localparam int MIX_MTI_BIT = 7;
  localparam int MIX_MEI_BIT = 11;

  // low mtvec bits that never hold base address
  localparam int MTVEC_ALIGN = 8;

  // interrupt flag plus 5-bit exception code
  localparam int CAUSE_W = 6;

  localparam int CNT_W = 64;

endpackage

/* source/csr_trap_regs.sv */
// machine trap registers and privilege level
// mstatus, mie, mip, mscratch, mepc, mcause, mtval, mtvec, mhartid,
// trap entry, MRET and interrupt qualification

`timescale 1ns/1ps

module csr_trap_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // CSR port from the access block
  input  csr_pkg::csr_addr_t         csr_addr_i,
  input  logic                       csr_we_i,
  input  csr_pkg::csr_data_t         csr_wdata_i,
  output csr_pkg::csr_data_t         rdata_o,
  output logic                       hit_o,

  // interrupt pins
  input  logic                       irq_software_i,
  input  logic                       irq_timer_i,
  input  logic                       irq_external_i,

  // trap control
  input  logic                       csr_save_cause_i,
  input  logic                       csr_restore_mret_i,
  input  logic                       csr_mtvec_init_i,
  input  csr_pkg::csr_data_t         csr_trap_pc_i,
  input  logic [csr_pkg::CAUSE_W-1:0] csr_mcause_i,
  input  csr_pkg::csr_data_t         csr_mtval_i,
  input  csr_pkg::csr_data_t         boot_addr_i,

  output csr_pkg::priv_lvl_e         priv_lvl_o,
  output csr_pkg::csr_data_t         csr_mepc_o,
  output csr_pkg::csr_data_t         csr_mtvec_o,
  output logic                       csr_mstatus_mie_o,
  output logic                       irq_pending_o
);

  import csr_pkg::*;

  priv_lvl_e          priv_lvl_q, priv_lvl_d;
  logic               mstatus_mie_q, mstatus_mie_d;
  logic               mstatus_mpie_q, mstatus_mpie_d;
  priv_lvl_e          mstatus_mpp_q, mstatus_mpp_d;
  // index 0 software, 1 timer, 2 external
  logic [2:0]         mie_q, mie_d;
  logic [2:0]         mip;
  csr_data_t          mscratch_q, mscratch_d;
  csr_data_t          mepc_q, mepc_d;
  logic [CAUSE_W-1:0] mcause_q, mcause_d;
  csr_data_t          mtval_q, mtval_d;
  csr_data_t          mtvec_q, mtvec_d;
  logic [1:0]         wr_mpp;

  assign mip    = {irq_external_i, irq_timer_i, irq_software_i};
  assign wr_mpp = csr_wdata_i[MSTATUS_MPP_HI:MSTATUS_MPP_LO];

  ////////////////////////////////////////////////////////////////////////////
  // read decode

  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (csr_addr_i)
      CSR_MSTATUS: begin
        rdata_o[MSTATUS_MIE_BIT]                = mstatus_mie_q;
        rdata_o[MSTATUS_MPIE_BIT]               = mstatus_mpie_q;
        rdata_o[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = mstatus_mpp_q;
      end
      CSR_MIE: begin
        rdata_o[MIX_MSI_BIT] = mie_q[0];
        rdata_o[MIX_MTI_BIT] = mie_q[1];
        rdata_o[MIX_MEI_BIT] = mie_q[2];
      end
      CSR_MIP: begin
        rdata_o[MIX_MSI_BIT] = mip[0];
        rdata_o[MIX_MTI_BIT] = mip[1];
        rdata_o[MIX_MEI_BIT] = mip[2];
      end
      CSR_MSCRATCH: rdata_o = mscratch_q;
      CSR_MEPC:     rdata_o = mepc_q;
      CSR_MCAUSE:   rdata_o = {mcause_q[CAUSE_W-1], 26'b0, mcause_q[CAUSE_W-2:0]};
      CSR_MTVAL:    rdata_o = mtval_q;
      CSR_MTVEC:    rdata_o = mtvec_q;
      CSR_MHARTID:  rdata_o = HART_ID;
      default:      hit_o   = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // next state with CSR write, then MRET, then trap entry on top

  always_comb begin
    priv_lvl_d     = priv_lvl_q;
    mstatus_mie_d  = mstatus_mie_q;
    mstatus_mpie_d = mstatus_mpie_q;
    mstatus_mpp_d  = mstatus_mpp_q;
    mie_d          = mie_q;
    mscratch_d     = mscratch_q;
    mepc_d         = mepc_q;
    mcause_d       = mcause_q;
    mtval_d        = mtval_q;
    mtvec_d        = mtvec_q;

    // vectored mode with base aligned to 256 bytes
    if (csr_mtvec_init_i) begin
      mtvec_d = {boot_addr_i[31:MTVEC_ALIGN], {(MTVEC_ALIGN-1){1'b0}}, 1'b1};
    end

    if (csr_we_i) begin
      case (csr_addr_i)
        CSR_MSTATUS: begin
          mstatus_mie_d  = csr_wdata_i[MSTATUS_MIE_BIT];
          mstatus_mpie_d = csr_wdata_i[MSTATUS_MPIE_BIT];
          // unsupported modes fall back to M
          mstatus_mpp_d  = (wr_mpp == PRIV_LVL_U) ? PRIV_LVL_U : PRIV_LVL_M;
        end
        CSR_MIE: begin
          mie_d = {csr_wdata_i[MIX_MEI_BIT], csr_wdata_i[MIX_MTI_BIT],
                   csr_wdata_i[MIX_MSI_BIT]};
        end
        CSR_MSCRATCH: mscratch_d = csr_wdata_i;
        CSR_MEPC:     mepc_d     = {csr_wdata_i[31:1], 1'b0};
        CSR_MCAUSE:   mcause_d   = {csr_wdata_i[31], csr_wdata_i[CAUSE_W-2:0]};
        CSR_MTVAL:    mtval_d    = csr_wdata_i;
        CSR_MTVEC: begin
          mtvec_d = {csr_wdata_i[31:MTVEC_ALIGN], {(MTVEC_ALIGN-1){1'b0}}, 1'b1};
        end
        default: ;
      endcase
    end

    if (csr_save_cause_i) begin
      // stack the interrupt enable and enter M
      mstatus_mpie_d = mstatus_mie_q;
      mstatus_mie_d  = 1'b0;
      mstatus_mpp_d  = priv_lvl_q;
      priv_lvl_d     = PRIV_LVL_M;
      mepc_d         = {csr_trap_pc_i[31:1], 1'b0};
      mcause_d       = csr_mcause_i;
      mtval_d        = csr_mtval_i;
    end else if (csr_restore_mret_i) begin
      priv_lvl_d     = mstatus_mpp_q;
      mstatus_mie_d  = mstatus_mpie_q;
      mstatus_mpie_d = 1'b1;
      mstatus_mpp_d  = PRIV_LVL_U;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_lvl_q     <= PRIV_LVL_M;
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b1;
      mstatus_mpp_q  <= PRIV_LVL_U;
      mie_q          <= '0;
      mscratch_q     <= '0;
      mepc_q         <= '0;
      mcause_q       <= '0;
      mtval_q        <= '0;
      mtvec_q        <= 32'h0000_0001;
    end else begin
      priv_lvl_q     <= priv_lvl_d;
      mstatus_mie_q  <= mstatus_mie_d;
      mstatus_mpie_q <= mstatus_mpie_d;
      mstatus_mpp_q  <= mstatus_mpp_d;
      mie_q          <= mie_d;
      mscratch_q     <= mscratch_d;
      mepc_q         <= mepc_d;
      mcause_q       <= mcause_d;
      mtval_q        <= mtval_d;
      mtvec_q        <= mtvec_d;
    end
  end

  assign priv_lvl_o        = priv_lvl_q;
  assign csr_mepc_o        = mepc_q;
  assign csr_mtvec_o       = mtvec_q;
  assign csr_mstatus_mie_o = mstatus_mie_q;

  // pins qualified by mie without a register in the path
  assign irq_pending_o = |(mip & mie_q);

endmodule

/* verification/csr_file_assertions.sv */
// concurrent checks on the CSR file outputs
// illegal flag, forced mepc/mtvec bits, interrupt pending

`timescale 1ns/1ps

module csr_file_assertions (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               csr_access_i,
  input logic               illegal_csr_insn_i,
  input csr_pkg::csr_data_t mepc_i,
  input csr_pkg::csr_data_t mtvec_i,
  input logic               irq_pending_i,
  input logic               irq_software_i,
  input logic               irq_timer_i,
  input logic               irq_external_i
);

  // illegal is only flagged for a real access
  illegal_needs_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_csr_insn_i |-> csr_access_i)
    else $error("illegal flag raised without a CSR access");

  mepc_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mepc_i[0] == 1'b0)
    else $error("mepc bit 0 is set");

  mtvec_low_byte: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mtvec_i[7:0] == 8'h01)
    else $error("mtvec low byte is not 0x01");

  // no pin high, nothing can be pending
  no_irq_no_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(irq_software_i | irq_timer_i | irq_external_i) |-> !irq_pending_i)
    else $error("interrupt pending with all interrupt inputs low");

endmodule

/* verification/csr_file_cases.txt */
// kind(1 rd 2 wr 3 set 4 clr 5 trap 6 mret 7 irq 8 retire f end) addr/cause data
// expected data (trap/mret: priv) and flag (illegal, mie or pending; +10 skips data)
1 300 00000000 00000080 0
1 305 00000000 00000001 0
2 340 deadbeef 00000000 0
1 340 00000000 deadbeef 0
3 340 0000ffff deadbeef 0
1 340 00000000 deadffff 0
4 340 ff00ff00 deadffff 0
1 340 00000000 00ad00ff 0
2 304 00000080 00000000 0
1 304 00000000 00000080 0
3 304 00000808 00000080 0
1 304 00000000 00000888 0
4 304 00000080 00000888 0
1 304 00000000 00000808 0
2 341 12345677 00000000 0
1 341 00000000 12345676 0
2 305 80001234 00000001 0
1 305 00000000 80001201 0
1 f14 00000000 00000001 0
2 f14 00000055 00000001 1
1 f14 00000000 00000001 0
2 344 00000888 00000000 1
1 344 00000000 00000000 0
1 7c0 00000000 00000000 1
3 300 00000008 00000080 0
1 300 00000000 00000088 0
5 002 00001003 00000003 0
1 341 00000000 00001002 0
1 342 00000000 00000002 0
1 343 00000000 00001003 0
1 300 00000000 00001880 0
4 300 00001800 00001880 0
6 000 00000000 00000000 1
1 340 00000000 00ad00ff 1
2 340 00000000 00ad00ff 1
5 02b 00002000 00000003 0
1 342 00000000 8000000b 0
1 340 00000000 00ad00ff 0
1 300 00000000 00000080 0
7 000 00000001 00000000 1
1 344 00000000 00000008 0
7 000 00000002 00000000 0
1 344 00000000 00000080 0
7 000 00000004 00000000 1
1 344 00000000 00000800 0
7 000 00000007 00000000 1
7 000 00000000 00000000 0
2 320 00000001 00000000 0
1 320 00000000 00000001 0
2 b00 12345678 00000000 10
1 b00 00000000 12345678 0
2 b80 00000abc 00000000 0
1 b80 00000000 00000abc 0
1 b00 00000000 12345678 0
1 b02 00000000 00000000 0
8 000 00000005 00000000 0
1 b02 00000000 00000005 0
2 b02 fffffffe 00000005 0
8 000 00000003 00000000 0
1 b02 00000000 00000001 0
1 b82 00000000 00000001 0
f 000 00000000 00000000 0

/* verification/csr_file_tb.sv */
// testbench for the machine-mode CSR file
// case file driven steps: CSR accesses, traps, MRET, interrupts, retires

`timescale 1ns/1ps

module csr_file_tb;

  import csr_pkg::*;

  localparam int    CLK_PERIOD     = 8;
  localparam int    RESET_CYCLES   = 16;
  localparam int    MAX_STEPS      = 128;
  localparam int    WORDS_PER_STEP = 5;
  localparam int    STEP_CYCLES    = 8;
  localparam int    TIMEOUT_MARGIN = 100;
  localparam string CASES_FILE     = "verification/csr_file_cases.txt";

  // step kinds 1 to 4 are CSR accesses with op = kind - 1
  localparam logic [31:0] K_READ   = 32'h1;
  localparam logic [31:0] K_CLEAR  = 32'h4;
  localparam logic [31:0] K_TRAP   = 32'h5;
  localparam logic [31:0] K_MRET   = 32'h6;
  localparam logic [31:0] K_IRQ    = 32'h7;
  localparam logic [31:0] K_RETIRE = 32'h8;
  localparam logic [31:0] K_END    = 32'hF;

  logic               clk_i;
  logic               rst_ni;
  logic               csr_access_i;
  csr_addr_t          csr_addr_i;
  csr_op_e            csr_op_i;
  logic               csr_op_en_i;
  csr_data_t          csr_wdata_i;
  csr_data_t          csr_rdata_o;
  logic               illegal_csr_insn_o;
  logic               irq_software_i;
  logic               irq_timer_i;
  logic               irq_external_i;
  logic               irq_pending_o;
  logic               csr_mstatus_mie_o;
  logic               csr_save_cause_i;
  logic               csr_restore_mret_i;
  csr_data_t          csr_trap_pc_i;
  logic [CAUSE_W-1:0] csr_mcause_i;
  csr_data_t          csr_mtval_i;
  logic               csr_mtvec_init_i;
  csr_data_t          boot_addr_i;
  csr_data_t          csr_mtvec_o;
  csr_data_t          csr_mepc_o;
  priv_lvl_e          priv_mode_o;
  logic               instr_ret_i;

  logic [31:0] cases_mem [0:MAX_STEPS*WORDS_PER_STEP-1];
  int          n_steps;
  int          step_idx;
  int          cycle_cnt   = 0;
  int          cycle_limit = MAX_STEPS * STEP_CYCLES + TIMEOUT_MARGIN;

  csr_file dut_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .csr_access_i       (csr_access_i),
    .csr_addr_i         (csr_addr_i),
    .csr_op_i           (csr_op_i),
    .csr_op_en_i        (csr_op_en_i),
    .csr_wdata_i        (csr_wdata_i),
    .csr_rdata_o        (csr_rdata_o),
    .illegal_csr_insn_o (illegal_csr_insn_o),
    .irq_software_i     (irq_software_i),
    .irq_timer_i        (irq_timer_i),
    .irq_external_i     (irq_external_i),
    .irq_pending_o      (irq_pending_o),
    .csr_mstatus_mie_o  (csr_mstatus_mie_o),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .csr_trap_pc_i      (csr_trap_pc_i),
    .csr_mcause_i       (csr_mcause_i),
    .csr_mtval_i        (csr_mtval_i),
    .csr_mtvec_init_i   (csr_mtvec_init_i),
    .boot_addr_i        (boot_addr_i),
    .csr_mtvec_o        (csr_mtvec_o),
    .csr_mepc_o         (csr_mepc_o),
    .priv_mode_o        (priv_mode_o),
    .instr_ret_i        (instr_ret_i)
  );

  bind csr_file csr_file_assertions u_assertions (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .csr_access_i       (csr_access_i),
    .illegal_csr_insn_i (illegal_csr_insn_o),
    .mepc_i             (csr_mepc_o),
    .mtvec_i            (csr_mtvec_o),
    .irq_pending_i      (irq_pending_o),
    .irq_software_i     (irq_software_i),
    .irq_timer_i        (irq_timer_i),
    .irq_external_i     (irq_external_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout, run did not finish within %0d cycles", cycle_limit);
      fail_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic fail_run();
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error %s: expected %08h, got %08h (step %0d)", name, expected, actual,
               step_idx);
      fail_run();
    end
  endtask

  // request and strobe inputs back to idle while irq pins keep their level
  task automatic drive_idle();
    csr_access_i       <= 1'b0;
    csr_op_en_i        <= 1'b0;
    csr_op_i           <= CSR_OP_READ;
    csr_save_cause_i   <= 1'b0;
    csr_restore_mret_i <= 1'b0;
    csr_mtvec_init_i   <= 1'b0;
    instr_ret_i        <= 1'b0;
  endtask

  task automatic load_cases();
    $readmemh(CASES_FILE, cases_mem);
    n_steps = 0;
    while (n_steps < MAX_STEPS && cases_mem[n_steps * WORDS_PER_STEP] != K_END) begin
      n_steps++;
    end
    if (n_steps == MAX_STEPS) begin
      $display("case file has no end marker within %0d steps", MAX_STEPS);
      fail_run();
    end
    cycle_limit = n_steps * STEP_CYCLES + TIMEOUT_MARGIN;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one step of the case file

  task automatic run_step(input int idx);
    logic [31:0] kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_data;
    logic [31:0] exp_flag;
    int          i;
    kind     = cases_mem[idx * WORDS_PER_STEP];
    addr     = cases_mem[idx * WORDS_PER_STEP + 1];
    data     = cases_mem[idx * WORDS_PER_STEP + 2];
    exp_data = cases_mem[idx * WORDS_PER_STEP + 3];
    exp_flag = cases_mem[idx * WORDS_PER_STEP + 4];

    @(posedge clk_i);
    drive_idle();
    if (kind >= K_READ && kind <= K_CLEAR) begin
      csr_access_i <= 1'b1;
      csr_op_en_i  <= 1'b1;
      csr_addr_i   <= addr[11:0];
      csr_op_i     <= csr_op_e'(2'(kind - 1));
      csr_wdata_i  <= data;
      // read data shows the value before this access
      @(negedge clk_i);
      if (!exp_flag[4]) begin
        check_value("csr_rdata_o", exp_data, csr_rdata_o);
        // return address and trap vector also leave the core directly
        if (addr[11:0] == CSR_MEPC) begin
          check_value("csr_mepc_o", exp_data, csr_mepc_o);
        end
        if (addr[11:0] == CSR_MTVEC) begin
          check_value("csr_mtvec_o", exp_data, csr_mtvec_o);
        end
      end
      check_value("illegal_csr_insn_o", {31'b0, exp_flag[0]}, {31'b0, illegal_csr_insn_o});
    end else if (kind == K_TRAP || kind == K_MRET) begin
      if (kind == K_TRAP) begin
        csr_save_cause_i <= 1'b1;
        csr_mcause_i     <= addr[CAUSE_W-1:0];
        csr_trap_pc_i    <= data;
        csr_mtval_i      <= data;
      end else begin
        csr_restore_mret_i <= 1'b1;
      end
      @(posedge clk_i);
      drive_idle();
      @(negedge clk_i);
      check_value("priv_mode_o", {30'b0, exp_data[1:0]}, {30'b0, priv_mode_o});
      check_value("csr_mstatus_mie_o", {31'b0, exp_flag[0]}, {31'b0, csr_mstatus_mie_o});
    end else if (kind == K_IRQ) begin
      irq_software_i <= data[0];
      irq_timer_i    <= data[1];
      irq_external_i <= data[2];
      @(negedge clk_i);
      check_value("irq_pending_o", {31'b0, exp_flag[0]}, {31'b0, irq_pending_o});
    end else if (kind == K_RETIRE) begin
      // one pulse per cycle until the next step drops it
      instr_ret_i <= 1'b1;
      for (i = 1; i < int'(data); i++) begin
        @(posedge clk_i);
      end
    end else begin
      $display("unknown step kind %0h at step %0d", kind, idx);
      fail_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    rst_ni             = 1'b0;
    csr_access_i       = 1'b0;
    csr_addr_i         = '0;
    csr_op_i           = CSR_OP_READ;
    csr_op_en_i        = 1'b0;
    csr_wdata_i        = '0;
    irq_software_i     = 1'b0;
    irq_timer_i        = 1'b0;
    irq_external_i     = 1'b0;
    csr_save_cause_i   = 1'b0;
    csr_restore_mret_i = 1'b0;
    csr_trap_pc_i      = '0;
    csr_mcause_i       = '0;
    csr_mtval_i        = '0;
    csr_mtvec_init_i   = 1'b0;
    boot_addr_i        = '0;
    instr_ret_i        = 1'b0;
    load_cases();

    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (step_idx = 0; step_idx < n_steps; step_idx++) begin
      run_step(step_idx);
    end
    @(posedge clk_i);
    drive_idle();
    repeat (2) @(posedge clk_i);

    $display("sim passed");
    $finish;
  end

endmodule
